// ==== Bender.yml ====
package:
  name: nic_core

export_include_dirs:
  - rtl

sources:
  - rtl/nic_pkg.sv
  - rtl/rx_err_filter.sv
  - rtl/ingress_arbiter.sv
  - rtl/egress_router.sv
  - rtl/nic_regs.sv
  - rtl/nic_core.sv
  - target: test
    files:
      - verification/nic_sva.sv
      - verification/nic_checker.sv
      - verification/nic_tb.sv

// ==== rtl/egress_router.sv ====
// Per-packet destination selection and demux to MAC 0, MAC 1 and host
module egress_router (
   input  logic                  core_clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  nic_pkg::axis_beat_t   in_beat,
   output logic                  in_ready,
   input  nic_pkg::port_config_t cfg,
   output logic [2:0]            out_valid,
   output nic_pkg::axis_beat_t   out_beat,
   input  logic [2:0]            out_ready
);

   nic_pkg::port_t dest_new;
   logic [1:0]     sel_new;
   logic [1:0]     sel_q;
   logic [1:0]     sel;
   logic           in_pkt;

   always_comb begin
      case (cfg.output_enable)
         nic_pkg::PORT0: dest_new = 2'd0;
         nic_pkg::PORT1: dest_new = 2'd1;
         nic_pkg::HOST:  dest_new = 2'd2;
         default:        dest_new = in_beat.tdest;
      endcase
   end

   // tdest 3 also goes to host
   assign sel_new = (dest_new == 2'd3) ? 2'd2 : dest_new;
   assign sel     = in_pkt ? sel_q : sel_new;

   assign out_valid = {3{in_valid}} & (3'b001 << sel);
   assign out_beat  = in_beat;
   assign in_ready  = out_ready[sel];

   // Choice is held from the first presented beat until tlast
   always_ff @(posedge core_clk) begin
      if (reset) begin
         sel_q  <= 2'd0;
         in_pkt <= 1'b0;
      end else if (in_valid) begin
         sel_q  <= sel;
         in_pkt <= !(in_ready && in_beat.tlast);
      end
   end

endmodule

// ==== rtl/ingress_arbiter.sv ====
// Packet-level round-robin merge of three sources with tid stamping and pause
module ingress_arbiter (
   input  logic                core_clk,
   input  logic                reset,
   input  logic [2:0]          src_valid,
   input  nic_pkg::axis_beat_t src_beat [3],
   output logic [2:0]          src_ready,
   input  logic                tpause,
   output logic                out_valid,
   output nic_pkg::axis_beat_t out_beat,
   input  logic                out_ready
);

   // Last or current grant, reused as the round-robin pointer
   logic [1:0] grant;
   logic       locked;
   logic [1:0] pick;
   logic       pick_ok;
   logic [1:0] cur;

   // Next requester after the last grant
   always_comb begin
      int idx;
      pick    = grant;
      pick_ok = 1'b0;
      for (int k = 1; k <= 3; k++) begin
         idx = (int'(grant) + k) % 3;
         if (!pick_ok && src_valid[idx]) begin
            pick    = 2'(idx);
            pick_ok = 1'b1;
         end
      end
   end

   assign cur       = locked ? grant : pick;
   assign out_valid = !tpause && (locked ? src_valid[grant] : pick_ok);
   assign src_ready = {3{out_valid && out_ready}} & (3'b001 << cur);

   always_comb begin
      out_beat     = src_beat[cur];
      out_beat.tid = cur;
   end

   // Grant is held from the first presented beat until tlast transfers
   always_ff @(posedge core_clk) begin
      if (reset) begin
         grant  <= 2'd2;
         locked <= 1'b0;
      end else if (out_valid) begin
         grant  <= cur;
         locked <= !(out_ready && out_beat.tlast);
      end
   end

endmodule

// ==== rtl/nic_consts.svh ====
// Stream widths, port count, filter buffer depth and APB register addresses
`ifndef NIC_CONSTS_SVH
`define NIC_CONSTS_SVH

// Stream data path
`define NIC_DATA_W     64
`define NIC_KEEP_W     8

// Port count and receive buffering
`define NIC_NUM_MAC    2
`define NIC_BUF_DEPTH  16

// APB register map, byte addresses
`define NIC_ADDR_PORT_CONFIG  8'h00
`define NIC_ADDR_DROPS_ERR0   8'h04
`define NIC_ADDR_DROPS_ERR1   8'h08
`define NIC_ADDR_DROPS_OVFL0  8'h0C
`define NIC_ADDR_DROPS_OVFL1  8'h10

`endif

// ==== rtl/nic_core.sv ====
// Top level with receive filters, ingress arbiter, egress router and registers
`include "nic_consts.svh"

module nic_core (
   input  logic                core_clk,
   input  logic                reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [7:0]          paddr,
   input  nic_pkg::reg_word_u  pwdata,
   output logic [31:0]         prdata,
   output logic                pready,
   output logic                pslverr,
   input  logic [`NIC_NUM_MAC-1:0] mac_rx_valid,
   input  nic_pkg::axis_beat_t mac_rx_beat [`NIC_NUM_MAC],
   input  logic                host_tx_valid,
   input  nic_pkg::axis_beat_t host_tx_beat,
   output logic                host_tx_ready,
   output logic [2:0]          tx_valid,
   output nic_pkg::axis_beat_t tx_beat,
   input  logic [2:0]          tx_ready
);

   logic [`NIC_NUM_MAC-1:0] filt_valid;
   logic [`NIC_NUM_MAC-1:0] filt_ready;
   nic_pkg::axis_beat_t     filt_beat [`NIC_NUM_MAC];
   nic_pkg::drop_evt_t      drops [`NIC_NUM_MAC];
   nic_pkg::port_config_t   cfg;
   logic                    arb_valid;
   logic                    arb_ready;
   nic_pkg::axis_beat_t     arb_beat;

   // ----------------------------------------------------------------------
   // MAC receive filters
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < `NIC_NUM_MAC; i++) begin : g_filter
      rx_err_filter u_rx_err_filter (
         .core_clk  (core_clk),
         .reset     (reset),
         .in_valid  (mac_rx_valid[i]),
         .in_beat   (mac_rx_beat[i]),
         .out_valid (filt_valid[i]),
         .out_beat  (filt_beat[i]),
         .out_ready (filt_ready[i]),
         .drops     (drops[i])
      );
   end

   // Source 2 is the host
   ingress_arbiter u_ingress_arbiter (
      .core_clk  (core_clk),
      .reset     (reset),
      .src_valid ({host_tx_valid, filt_valid}),
      .src_beat  ('{filt_beat[0], filt_beat[1], host_tx_beat}),
      .src_ready ({host_tx_ready, filt_ready}),
      .tpause    (cfg.tpause),
      .out_valid (arb_valid),
      .out_beat  (arb_beat),
      .out_ready (arb_ready)
   );

   egress_router u_egress_router (
      .core_clk  (core_clk),
      .reset     (reset),
      .in_valid  (arb_valid),
      .in_beat   (arb_beat),
      .in_ready  (arb_ready),
      .cfg       (cfg),
      .out_valid (tx_valid),
      .out_beat  (tx_beat),
      .out_ready (tx_ready)
   );

   nic_regs u_nic_regs (
      .core_clk (core_clk),
      .reset    (reset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .drops    (drops),
      .cfg      (cfg)
   );

endmodule

// ==== rtl/nic_pkg.sv ====
// Package with stream beat, drop event, port configuration and register word types
`include "nic_consts.svh"

package nic_pkg;

   // Port numbering, 3 is treated as host
   typedef logic [1:0] port_t;

   // One stream beat with its sideband
   typedef struct packed {
      logic [`NIC_DATA_W-1:0] tdata;
      logic [`NIC_KEEP_W-1:0] tkeep;
      logic                   tlast;
      port_t                  tid;
      port_t                  tdest;
      logic                   err;
   } axis_beat_t;

   // Egress selection modes
   typedef enum logic [1:0] {
      PORT0    = 2'd0,
      PORT1    = 2'd1,
      HOST     = 2'd2,
      USE_META = 2'd3
   } out_enable_e;

   // PORT_CONFIG register layout
   typedef struct packed {
      logic [28:0] rsvd;
      logic        tpause;
      out_enable_e output_enable;
   } port_config_t;

   // APB write word, raw or as port configuration
   typedef union packed {
      logic [31:0]  raw;
      port_config_t port_config;
   } reg_word_u;

   // Single-cycle drop pulses from a receive filter
   typedef struct packed {
      logic err_drop;
      logic ovfl_drop;
   } drop_evt_t;

endpackage

// ==== rtl/nic_regs.sv ====
// APB register block with port configuration and saturating drop counters
`include "nic_consts.svh"

module nic_regs (
   input  logic                core_clk,
   input  logic                reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [7:0]          paddr,
   input  nic_pkg::reg_word_u  pwdata,
   output logic [31:0]         prdata,
   output logic                pready,
   output logic                pslverr,
   input  nic_pkg::drop_evt_t  drops [`NIC_NUM_MAC],
   output nic_pkg::port_config_t cfg
);

   // Counter order is err0, err1, ovfl0, ovfl1
   logic [31:0] drop_cnt [4];
   logic [3:0]  drop_inc;
   logic        access;
   logic        addr_hit;
   logic        is_cnt;
   logic [31:0] rd_data;

   assign access   = psel && penable;
   assign drop_inc = {drops[1].ovfl_drop, drops[0].ovfl_drop,
                      drops[1].err_drop,  drops[0].err_drop};

   // ----------------------------------------------------------------------
   // Address decode and read mux
   // ----------------------------------------------------------------------
   always_comb begin
      rd_data  = '0;
      addr_hit = 1'b1;
      is_cnt   = 1'b1;
      case (paddr)
         `NIC_ADDR_PORT_CONFIG: begin
            rd_data = cfg;
            is_cnt  = 1'b0;
         end
         `NIC_ADDR_DROPS_ERR0:  rd_data = drop_cnt[0];
         `NIC_ADDR_DROPS_ERR1:  rd_data = drop_cnt[1];
         `NIC_ADDR_DROPS_OVFL0: rd_data = drop_cnt[2];
         `NIC_ADDR_DROPS_OVFL1: rd_data = drop_cnt[3];
         default: begin
            addr_hit = 1'b0;
            is_cnt   = 1'b0;
         end
      endcase
   end

   // No wait states
   assign pready  = access;
   assign prdata  = rd_data;
   assign pslverr = access && (!addr_hit || (pwrite && is_cnt));

   // ----------------------------------------------------------------------
   // Configuration and counters
   // ----------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         cfg <= '{rsvd: '0, tpause: 1'b0, output_enable: nic_pkg::PORT0};
         for (int i = 0; i < 4; i++) begin
            drop_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            // Hold at all ones
            if (drop_inc[i] && drop_cnt[i] != '1) begin
               drop_cnt[i] <= drop_cnt[i] + 32'd1;
            end
         end
         if (access && pwrite && paddr == `NIC_ADDR_PORT_CONFIG) begin
            cfg.output_enable <= pwdata.port_config.output_enable;
            cfg.tpause        <= pwdata.port_config.tpause;
         end
      end
   end

endmodule

// ==== rtl/rx_err_filter.sv ====
// Store-and-forward receive filter that drops errored and oversize MAC packets
`include "nic_consts.svh"

module rx_err_filter (
   input  logic                core_clk,
   input  logic                reset,
   input  logic                in_valid,
   input  nic_pkg::axis_beat_t in_beat,
   output logic                out_valid,
   output nic_pkg::axis_beat_t out_beat,
   input  logic                out_ready,
   output nic_pkg::drop_evt_t  drops
);

   localparam int AW = $clog2(`NIC_BUF_DEPTH);

   nic_pkg::axis_beat_t mem [`NIC_BUF_DEPTH];

   // Extra pointer bit tells full from empty
   logic [AW:0] wr_ptr;
   logic [AW:0] commit_ptr;
   logic [AW:0] rd_ptr;
   logic        pkt_err;
   logic        pkt_ovfl;
   logic        has_space;
   logic        beat_err;
   logic        beat_ovfl;
   logic        wr_en;

   assign has_space = (wr_ptr ^ rd_ptr) != {1'b1, {AW{1'b0}}};

   // Packet status including the arriving beat
   assign beat_err  = pkt_err || in_beat.err;
   assign beat_ovfl = pkt_ovfl || !has_space;
   assign wr_en     = in_valid && !beat_ovfl;

   // Only committed packets are visible downstream
   assign out_valid = rd_ptr != commit_ptr;
   assign out_beat  = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge core_clk) begin
      if (wr_en) begin
         mem[wr_ptr[AW-1:0]] <= in_beat;
      end
   end

   // ----------------------------------------------------------------------
   // Tentative write, commit or rewind at tlast
   // ----------------------------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         rd_ptr     <= '0;
         pkt_err    <= 1'b0;
         pkt_ovfl   <= 1'b0;
         drops      <= '0;
      end else begin
         drops <= '0;
         if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (in_valid) begin
            if (in_beat.tlast) begin
               pkt_err  <= 1'b0;
               pkt_ovfl <= 1'b0;
               // Error wins over overflow
               if (beat_err) begin
                  wr_ptr         <= commit_ptr;
                  drops.err_drop <= 1'b1;
               end else if (beat_ovfl) begin
                  wr_ptr          <= commit_ptr;
                  drops.ovfl_drop <= 1'b1;
               end else begin
                  wr_ptr     <= wr_ptr + 1'b1;
                  commit_ptr <= wr_ptr + 1'b1;
               end
            end else begin
               pkt_err  <= beat_err;
               pkt_ovfl <= beat_ovfl;
               if (wr_en) begin
                  wr_ptr <= wr_ptr + 1'b1;
               end
            end
         end
      end
   end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/nic_pkg.sv
rtl/rx_err_filter.sv
rtl/ingress_arbiter.sv
rtl/egress_router.sv
rtl/nic_regs.sv
rtl/nic_core.sv
verification/nic_sva.sv
verification/nic_checker.sv
verification/nic_tb.sv

// ==== verification/nic_checker.sv ====
// Reference model of the NIC core with per-source expected queues and output comparison
`include "nic_consts.svh"

module nic_checker (
   input  logic                core_clk,
   input  logic                reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [7:0]          paddr,
   input  nic_pkg::reg_word_u  pwdata,
   input  logic [31:0]         prdata,
   input  logic                pslverr,
   input  logic [1:0]          mac_rx_valid,
   input  nic_pkg::axis_beat_t mac_rx_beat [2],
   input  logic                host_tx_valid,
   input  nic_pkg::axis_beat_t host_tx_beat,
   input  logic                host_tx_ready,
   input  logic [2:0]          tx_valid,
   input  nic_pkg::axis_beat_t tx_beat,
   input  logic [2:0]          tx_ready,
   output int                  err_count,
   output logic                idle
);

   // One expected beat with its source and output port
   typedef struct packed {
      logic [1:0]          src;
      logic [1:0]          port;
      nic_pkg::axis_beat_t beat;
   } exp_t;

   exp_t                  exp_q [$];
   nic_pkg::axis_beat_t   pkt_buf [2][64];
   int                    pkt_len [2];
   logic                  pkt_err [2];
   nic_pkg::out_enable_e  oe;
   logic                  tpause;
   // Order err0, err1, ovfl0, ovfl1
   logic [31:0]           drop_exp [4];
   logic                  busy;
   logic [1:0]            cur_src;
   logic [1:0]            last_src;

   function automatic logic [1:0] route(logic [1:0] tdest);
      if (oe != nic_pkg::USE_META) begin
         return oe;
      end
      return (tdest == 2'd3) ? 2'd2 : tdest;
   endfunction

   function automatic logic pending(logic [1:0] src);
      foreach (exp_q[i]) begin
         if (exp_q[i].src == src) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic report_mismatch(string name, logic [95:0] want, logic [95:0] got);
      err_count++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, want, got);
   endtask

   always @(posedge core_clk) begin
      logic [2:0]  waiting;
      int          idx;
      exp_t        e;
      logic        known;
      logic [31:0] want_rd;
      if (reset) begin
         exp_q.delete();
         err_count = 0;
         oe        = nic_pkg::PORT0;
         tpause    = 1'b0;
         busy      = 1'b0;
         cur_src   = 2'd3;
         last_src  = 2'd3;
         for (int m = 0; m < 2; m++) begin
            pkt_len[m] = 0;
            pkt_err[m] = 1'b0;
         end
         for (int i = 0; i < 4; i++) begin
            drop_exp[i] = '0;
         end
      end else begin
         // Sources holding a packet before this edge
         waiting = {host_tx_valid, pending(2'd1), pending(2'd0)};
         if (tpause && tx_valid != 3'b000) begin
            report_mismatch("tx_valid", 96'd0, 96'(tx_valid));
         end

         // ---------------------------------------------------------------
         // Round-robin rule on each newly presented packet
         // ---------------------------------------------------------------
         if (tx_valid != 3'b000 && !busy) begin
            busy    = 1'b1;
            cur_src = tx_beat.tid;
            if (cur_src == last_src && (waiting & ~(3'b001 << cur_src)) != 3'b000) begin
               err_count++;
               $display("Round-robin fault at %0t: source %0d served twice while another waited",
                        $time, cur_src);
            end
         end

         // MAC packets are kept only when clean and at most one buffer long
         for (int m = 0; m < 2; m++) begin
            if (mac_rx_valid[m]) begin
               if (pkt_len[m] < 64) begin
                  pkt_buf[m][pkt_len[m]] = mac_rx_beat[m];
               end
               pkt_len[m]++;
               pkt_err[m] = pkt_err[m] || mac_rx_beat[m].err;
               if (mac_rx_beat[m].tlast) begin
                  if (pkt_err[m]) begin
                     drop_exp[m]++;
                  end else if (pkt_len[m] > `NIC_BUF_DEPTH) begin
                     drop_exp[2 + m]++;
                  end else begin
                     for (int i = 0; i < pkt_len[m]; i++) begin
                        e.src      = 2'(m);
                        e.port     = route(pkt_buf[m][0].tdest);
                        e.beat     = pkt_buf[m][i];
                        e.beat.tid = 2'(m);
                        exp_q.push_back(e);
                     end
                  end
                  pkt_len[m] = 0;
                  pkt_err[m] = 1'b0;
               end
            end
         end

         if (host_tx_valid && host_tx_ready) begin
            e.src      = 2'd2;
            e.port     = route(host_tx_beat.tdest);
            e.beat     = host_tx_beat;
            e.beat.tid = 2'd2;
            exp_q.push_back(e);
         end

         // ---------------------------------------------------------------
         // Output beats against the head of their source's queue
         // ---------------------------------------------------------------
         for (int p = 0; p < 3; p++) begin
            if (tx_valid[p] && tx_ready[p]) begin
               if (busy && tx_beat.tid != cur_src) begin
                  err_count++;
                  $display("Source %0d interleaved into a packet of source %0d at %0t",
                           tx_beat.tid, cur_src, $time);
               end
               idx = -1;
               foreach (exp_q[i]) begin
                  if (idx < 0 && exp_q[i].src == tx_beat.tid) begin
                     idx = i;
                  end
               end
               if (idx < 0) begin
                  err_count++;
                  $display("Unexpected beat on tx port %0d from source %0d at %0t",
                           p, tx_beat.tid, $time);
               end else begin
                  if (exp_q[idx].port != 2'(p)) begin
                     report_mismatch("tx port", 96'(exp_q[idx].port), 96'(p));
                  end
                  if (tx_beat != exp_q[idx].beat) begin
                     report_mismatch("tx_beat", 96'(exp_q[idx].beat), 96'(tx_beat));
                  end
                  exp_q.delete(idx);
               end
               if (tx_beat.tlast) begin
                  busy     = 1'b0;
                  last_src = tx_beat.tid;
               end
            end
         end

         // APB responses and the configuration shadow
         if (psel && penable) begin
            known   = 1'b1;
            want_rd = '0;
            case (paddr)
               `NIC_ADDR_PORT_CONFIG: want_rd = {29'd0, tpause, oe};
               `NIC_ADDR_DROPS_ERR0:  want_rd = drop_exp[0];
               `NIC_ADDR_DROPS_ERR1:  want_rd = drop_exp[1];
               `NIC_ADDR_DROPS_OVFL0: want_rd = drop_exp[2];
               `NIC_ADDR_DROPS_OVFL1: want_rd = drop_exp[3];
               default:               known   = 1'b0;
            endcase
            if (!pwrite && known && prdata != want_rd) begin
               report_mismatch("prdata", 96'(want_rd), 96'(prdata));
            end
            if (pslverr != (!known || (pwrite && paddr != `NIC_ADDR_PORT_CONFIG))) begin
               report_mismatch("pslverr", 96'(!pslverr), 96'(pslverr));
            end
            if (pwrite && paddr == `NIC_ADDR_PORT_CONFIG) begin
               oe     = pwdata.port_config.output_enable;
               tpause = pwdata.port_config.tpause;
            end
         end else if (pslverr) begin
            report_mismatch("pslverr", 96'd0, 96'(pslverr));
         end
      end
      idle = exp_q.size() == 0 && pkt_len[0] == 0 && pkt_len[1] == 0 && !busy;
   end

endmodule

// ==== verification/nic_sva.sv ====
// Bound assertions for output stability, packet continuity and APB pready on the NIC top level
module nic_sva (
   input logic                core_clk,
   input logic                reset,
   input logic                psel,
   input logic                penable,
   input logic                pready,
   input logic                tpause,
   input logic [2:0]          tx_valid,
   input logic [2:0]          tx_ready,
   input nic_pkg::axis_beat_t tx_beat
);

   int         fail_cnt = 0;
   logic [2:0] mid_pkt;

   // Per port, set between the first and the last transferred beat
   always @(posedge core_clk) begin
      if (reset) begin
         mid_pkt <= '0;
      end else begin
         for (int p = 0; p < 3; p++) begin
            if (tx_valid[p] && tx_ready[p]) begin
               mid_pkt[p] <= !tx_beat.tlast;
            end
         end
      end
   end

   for (genvar p = 0; p < 3; p++) begin : g_port
      a_hold_stable: assert property (@(posedge core_clk) disable iff (reset)
         tx_valid[p] && !tx_ready[p] |=> tpause || (tx_valid[p] && $stable(tx_beat)))
         else begin
            fail_cnt++;
            $error("tx port %0d changed while stalled", p);
         end

      a_no_gap: assert property (@(posedge core_clk) disable iff (reset)
         mid_pkt[p] |-> tx_valid[p] || tpause)
         else begin
            fail_cnt++;
            $error("tx port %0d valid dropped inside a packet", p);
         end
   end

   a_pready: assert property (@(posedge core_clk) disable iff (reset)
      psel && penable |-> pready)
      else begin
         fail_cnt++;
         $error("APB access phase without pready");
      end

endmodule

bind nic_core nic_sva u_nic_sva (
   .core_clk (core_clk),
   .reset    (reset),
   .psel     (psel),
   .penable  (penable),
   .pready   (pready),
   .tpause   (cfg.tpause),
   .tx_valid (tx_valid),
   .tx_ready (tx_ready),
   .tx_beat  (tx_beat)
);

// ==== verification/nic_tb.sv ====
// Testbench top with clock, reset, APB tasks, stimulus table, row loop and final status
`include "nic_consts.svh"

module nic_tb;

   localparam int TIMEOUT = 1000;
   localparam int NROWS   = 20;

   // Source 3 means all three sources send together
   typedef struct packed {
      logic [1:0] src;
      logic [7:0] len;
      logic [1:0] npkt;
      logic       err;
      logic [1:0] tdest;
      logic [1:0] oe;
      logic [7:0] pause;
      logic       gaps;
   } row_t;

   // src, len, npkt, err, tdest, oe, pause cycles, random ready gaps
   localparam row_t ROWS [NROWS] = '{
      '{0, 4, 1, 0, 0, 0, 0, 0}, '{1, 3, 1, 0, 0, 0, 0, 0}, '{2, 5, 1, 0, 0, 0, 0, 0},
      '{0, 2, 1, 0, 0, 1, 0, 0}, '{2, 1, 1, 0, 0, 1, 0, 0},
      '{1, 6, 1, 0, 0, 2, 0, 0}, '{2, 2, 1, 0, 0, 2, 0, 0},
      '{0, 3, 1, 0, 0, 3, 0, 0}, '{1, 3, 1, 0, 1, 3, 0, 0},
      '{2, 3, 1, 0, 2, 3, 0, 0}, '{0, 3, 1, 0, 3, 3, 0, 0},
      '{0, 5, 1, 1, 0, 0, 0, 0}, '{1, 3, 1, 1, 0, 0, 0, 0},
      '{0, 20, 1, 0, 0, 0, 0, 0}, '{1, 17, 1, 0, 0, 0, 0, 0}, '{0, 16, 1, 0, 0, 0, 0, 0},
      '{3, 4, 2, 0, 0, 3, 0, 1}, '{3, 4, 2, 0, 1, 3, 0, 1}, '{3, 2, 2, 0, 2, 3, 0, 1},
      '{3, 3, 1, 0, 2, 2, 12, 0}
   };

   logic                core_clk = 1'b0;
   logic                reset;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [7:0]          paddr;
   nic_pkg::reg_word_u  pwdata;
   logic [31:0]         prdata;
   logic                pready;
   logic                pslverr;
   logic [1:0]          mac_rx_valid;
   nic_pkg::axis_beat_t mac_rx_beat [2];
   logic                host_tx_valid;
   nic_pkg::axis_beat_t host_tx_beat;
   logic                host_tx_ready;
   logic [2:0]          tx_valid;
   nic_pkg::axis_beat_t tx_beat;
   logic [2:0]          tx_ready = 3'b111;
   logic                gaps = 1'b0;
   int                  chk_errors;
   logic                idle;
   int                  tb_errors = 0;
   int                  total;

   nic_core u_nic_core (
      .core_clk (core_clk), .reset (reset),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
      .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
      .mac_rx_valid (mac_rx_valid), .mac_rx_beat (mac_rx_beat),
      .host_tx_valid (host_tx_valid), .host_tx_beat (host_tx_beat),
      .host_tx_ready (host_tx_ready),
      .tx_valid (tx_valid), .tx_beat (tx_beat), .tx_ready (tx_ready)
   );

   nic_checker u_checker (
      .core_clk (core_clk), .reset (reset),
      .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
      .pwdata (pwdata), .prdata (prdata), .pslverr (pslverr),
      .mac_rx_valid (mac_rx_valid), .mac_rx_beat (mac_rx_beat),
      .host_tx_valid (host_tx_valid), .host_tx_beat (host_tx_beat),
      .host_tx_ready (host_tx_ready),
      .tx_valid (tx_valid), .tx_beat (tx_beat), .tx_ready (tx_ready),
      .err_count (chk_errors), .idle (idle)
   );

   always #20 core_clk = ~core_clk;

   // Random stalls on all three outputs when a row asks for them
   always @(negedge core_clk) begin
      tx_ready = gaps ? 3'($urandom) : 3'b111;
   end

   // ---------------------------------------------------------------------
   // APB and stream drivers
   // ---------------------------------------------------------------------
   task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data);
      int cnt;
      @(negedge core_clk);
      psel       = 1'b1;
      pwrite     = write;
      paddr      = addr;
      pwdata.raw = data;
      penable    = 1'b0;
      @(negedge core_clk);
      penable = 1'b1;
      cnt     = 0;
      do begin
         @(posedge core_clk);
         cnt++;
      end while (!pready && cnt < TIMEOUT);
      if (!pready) begin
         tb_errors++;
         $display("APB access to address %h never saw pready", addr);
      end
      @(negedge core_clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_all_regs();
      apb_access(1'b0, `NIC_ADDR_PORT_CONFIG, '0);
      apb_access(1'b0, `NIC_ADDR_DROPS_ERR0, '0);
      apb_access(1'b0, `NIC_ADDR_DROPS_ERR1, '0);
      apb_access(1'b0, `NIC_ADDR_DROPS_OVFL0, '0);
      apb_access(1'b0, `NIC_ADDR_DROPS_OVFL1, '0);
   endtask

   function automatic nic_pkg::axis_beat_t make_beat(logic last, logic err, logic [1:0] tdest);
      nic_pkg::axis_beat_t b;
      b.tdata = {$urandom, $urandom};
      b.tkeep = last ? 8'h0F : 8'hFF;
      b.tlast = last;
      // Arbiter must overwrite this
      b.tid   = 2'd3;
      b.tdest = tdest;
      b.err   = err;
      return b;
   endfunction

   task automatic send_mac(input int m, input row_t r);
      int bad;
      for (int p = 0; p < r.npkt; p++) begin
         bad = r.err ? int'($urandom % r.len) : -1;
         for (int i = 0; i < r.len; i++) begin
            @(negedge core_clk);
            mac_rx_valid[m] = 1'b1;
            mac_rx_beat[m]  = make_beat(i == r.len - 1, i == bad, r.tdest);
         end
      end
      @(negedge core_clk);
      mac_rx_valid[m] = 1'b0;
   endtask

   task automatic send_host(input row_t r);
      int cnt;
      for (int p = 0; p < r.npkt; p++) begin
         for (int i = 0; i < r.len; i++) begin
            @(negedge core_clk);
            host_tx_valid = 1'b1;
            host_tx_beat  = make_beat(i == r.len - 1, 1'b0, r.tdest);
            cnt = 0;
            do begin
               @(posedge core_clk);
               cnt++;
            end while (!host_tx_ready && cnt < TIMEOUT);
            if (!host_tx_ready) begin
               tb_errors++;
               $display("Host input never accepted a beat");
            end
         end
      end
      @(negedge core_clk);
      host_tx_valid = 1'b0;
   endtask

   task automatic run_row(input row_t r);
      int cnt;
      apb_access(1'b1, `NIC_ADDR_PORT_CONFIG, {29'd0, r.pause != 0, r.oe});
      gaps = r.gaps;
      fork
         if (r.src == 0 || r.src == 3) send_mac(0, r);
         if (r.src == 1 || r.src == 3) send_mac(1, r);
         if (r.src >= 2) send_host(r);
         if (r.pause != 0) begin
            repeat (r.pause) @(negedge core_clk);
            apb_access(1'b1, `NIC_ADDR_PORT_CONFIG, {30'd0, r.oe});
         end
      join
      cnt = 0;
      while (!idle && cnt < TIMEOUT) begin
         @(posedge core_clk);
         cnt++;
      end
      if (!idle) begin
         tb_errors++;
         $display("Packets still outstanding after the drain timeout");
      end
      gaps = 1'b0;
   endtask

   // ---------------------------------------------------------------------
   // Main sequence
   // ---------------------------------------------------------------------
   initial begin
      void'($urandom(32'h2370556d));
      reset          = 1'b1;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      mac_rx_valid   = '0;
      mac_rx_beat[0] = '0;
      mac_rx_beat[1] = '0;
      host_tx_valid  = 1'b0;
      host_tx_beat   = '0;
      repeat (8) @(posedge core_clk);
      @(negedge core_clk);
      reset = 1'b0;

      // Defaults and error responses
      read_all_regs();
      apb_access(1'b0, 8'h14, '0);
      apb_access(1'b1, `NIC_ADDR_DROPS_ERR0, 32'h0000_ffff);
      apb_access(1'b1, `NIC_ADDR_DROPS_OVFL1, 32'h1234_5678);

      for (int i = 0; i < NROWS; i++) begin
         run_row(ROWS[i]);
      end
      read_all_regs();

      total = chk_errors + u_nic_core.u_nic_sva.fail_cnt + tb_errors;
      $display("Error counts: checker %0d, assertions %0d, testbench %0d",
               chk_errors, u_nic_core.u_nic_sva.fail_cnt, tb_errors);
      if (total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Overall run limit
   initial begin
      #400000;
      $display("Simulation did not finish within the time limit");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule
